//--- lsu_pkg.sv
`include "mem_stage_defines.svh"

package lsu_pkg;

  typedef enum logic [3:0] {
    NONE,
    LB,
    LH,
    LW,
    LD,
    LBU,
    LHU,
    LWU,
    SB,
    SH,
    SW,
    SD
  } mem_op_e;

  // size code on the memory port
  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_D
  } access_size_e;

  typedef logic [2:0] byte_off_t;

  typedef struct packed {
    logic [`XLEN-4:0] dw_idx;
    byte_off_t        off;
  } ex_addr_t;

  // address for memory ops, alu result for everything else
  typedef union packed {
    ex_addr_t         addr;
    logic [`XLEN-1:0] result;
  } ex_word_u;

  function automatic logic is_load(mem_op_e op);
    return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {SB, SH, SW, SD};
  endfunction

endpackage

//--- mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             ex_valid,
  input  lsu_pkg::mem_op_e ex_mem_op,
  input  logic             wb_allowin,
  input  logic             mem_rw_ready,
  output logic             mem_allowin,
  output logic             capture,
  output logic             mem_to_wb_valid,
  output logic             mem_rw_valid,
  output logic             rsp_take,
  output logic             mem_busy
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_RETN
  } acc_state_e;

  acc_state_e state;
  acc_state_e state_nxt;
  logic       stage_valid;
  logic       hold_acc;
  logic       hold_load;
  logic       ex_acc;
  logic       ready_go;

  assign ex_acc = lsu_pkg::is_load(ex_mem_op) || lsu_pkg::is_store(ex_mem_op);

  // non-memory items are done at once, memory items once data is back
  assign ready_go        = !hold_acc || (state == ST_RETN);
  assign mem_allowin     = !stage_valid || (ready_go && wb_allowin);
  assign capture         = ex_valid && mem_allowin;
  assign mem_to_wb_valid = stage_valid && ready_go;
  assign mem_rw_valid    = (state == ST_ADDR);
  assign rsp_take        = mem_rw_valid && mem_rw_ready;
  assign mem_busy        = stage_valid && hold_load && (state != ST_RETN);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
      hold_acc    <= 1'b0;
      hold_load   <= 1'b0;
    end else if (mem_allowin) begin
      stage_valid <= ex_valid;
      hold_acc    <= ex_valid && ex_acc;
      hold_load   <= ex_valid && lsu_pkg::is_load(ex_mem_op);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (capture && ex_acc) begin
          state_nxt = ST_ADDR;
        end
      end
      ST_ADDR: begin
        if (rsp_take) begin
          state_nxt = ST_RETN;
        end
      end
      ST_RETN: begin
        // wait for write-back to take the item
        if (wb_allowin) begin
          state_nxt = (capture && ex_acc) ? ST_ADDR : ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- mem_load_unit.sv
`timescale 1ns/100ps
`include "mem_stage_defines.svh"

module mem_load_unit (
  input  logic              clk,
  input  logic              rsp_take,
  input  lsu_pkg::mem_op_e  mem_op,
  input  lsu_pkg::ex_word_u mem_word,
  input  logic [`XLEN-1:0]  mem_r_data,
  output logic [`XLEN-1:0]  wb_data
);

  logic [`XLEN-1:0] load_ext;
  logic [`XLEN-1:0] load_q;

  // data arrives at the low bits
  always_comb begin
    case (mem_op)
      lsu_pkg::LB:  load_ext = {{(`XLEN-8){mem_r_data[7]}}, mem_r_data[7:0]};
      lsu_pkg::LH:  load_ext = {{(`XLEN-16){mem_r_data[15]}}, mem_r_data[15:0]};
      lsu_pkg::LW:  load_ext = {{(`XLEN-32){mem_r_data[31]}}, mem_r_data[31:0]};
      lsu_pkg::LBU: load_ext = {{(`XLEN-8){1'b0}}, mem_r_data[7:0]};
      lsu_pkg::LHU: load_ext = {{(`XLEN-16){1'b0}}, mem_r_data[15:0]};
      lsu_pkg::LWU: load_ext = {{(`XLEN-32){1'b0}}, mem_r_data[31:0]};
      default:      load_ext = mem_r_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rsp_take) begin
      load_q <= load_ext;
    end
  end

  // stores fall through with their address word
  assign wb_data = lsu_pkg::is_load(mem_op) ? load_q : mem_word.result;

endmodule

//--- mem_req_gen.sv
`timescale 1ns/100ps
`include "mem_stage_defines.svh"

module mem_req_gen (
  input  logic                  clk,
  input  logic                  capture,
  input  pipe_pkg::pc_t         ex_pc,
  input  pipe_pkg::inst_t       ex_inst,
  input  lsu_pkg::ex_word_u     ex_word,
  input  logic [`XLEN-1:0]      ex_store_data,
  input  lsu_pkg::mem_op_e      ex_mem_op,
  input  pipe_pkg::reg_addr_t   ex_rd_addr,
  input  logic                  ex_rd_ena,
  output pipe_pkg::pc_t         mem_pc,
  output pipe_pkg::inst_t       mem_inst,
  output lsu_pkg::ex_word_u     mem_word,
  output lsu_pkg::mem_op_e      mem_op,
  output pipe_pkg::reg_addr_t   mem_rd_addr,
  output logic                  mem_rd_ena,
  output logic [`XLEN-1:0]      mem_rw_addr,
  output logic                  mem_rw_req,
  output lsu_pkg::access_size_e mem_rw_size,
  output logic [7:0]            mem_rw_strb,
  output logic [`XLEN-1:0]      mem_w_data
);

  logic [`XLEN-1:0] store_data_q;
  logic [7:0]       size_mask;
  logic [`XLEN-1:0] data_mask;

  // payload, held while the item sits in the stage
  always_ff @(posedge clk) begin
    if (capture) begin
      mem_pc       <= ex_pc;
      mem_inst     <= ex_inst;
      mem_word     <= ex_word;
      mem_op       <= ex_mem_op;
      mem_rd_addr  <= ex_rd_addr;
      mem_rd_ena   <= ex_rd_ena;
      store_data_q <= ex_store_data;
    end
  end

  always_comb begin
    case (mem_op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: mem_rw_size = lsu_pkg::SIZE_B;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: mem_rw_size = lsu_pkg::SIZE_H;
      lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: mem_rw_size = lsu_pkg::SIZE_W;
      default:                                mem_rw_size = lsu_pkg::SIZE_D;
    endcase
  end

  // one bit per byte covered by the access
  always_comb begin
    case (mem_rw_size)
      lsu_pkg::SIZE_B: size_mask = 8'h01;
      lsu_pkg::SIZE_H: size_mask = 8'h03;
      lsu_pkg::SIZE_W: size_mask = 8'h0f;
      default:         size_mask = 8'hff;
    endcase
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      data_mask[8*i +: 8] = {8{size_mask[i]}};
    end
  end

  assign mem_rw_addr = mem_word.result;
  assign mem_rw_req  = lsu_pkg::is_store(mem_op);
  assign mem_w_data  = store_data_q & data_mask;

  // strobe lines up with the byte lanes of the doubleword
  assign mem_rw_strb = size_mask << mem_word.addr.off;

endmodule

//--- mem_stage.f
+incdir+.
lsu_pkg.sv
pipe_pkg.sv
mem_ctrl.sv
mem_req_gen.sv
mem_load_unit.sv
mem_stage.sv
mem_stage_asserts.sv
tb_mem_stage.sv

//--- mem_stage.sv
`timescale 1ns/100ps
`include "mem_stage_defines.svh"

module mem_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid,
  input  pipe_pkg::pc_t         ex_pc,
  input  pipe_pkg::inst_t       ex_inst,
  input  lsu_pkg::ex_word_u     ex_word,
  input  logic [`XLEN-1:0]      ex_store_data,
  input  lsu_pkg::mem_op_e      ex_mem_op,
  input  pipe_pkg::reg_addr_t   ex_rd_addr,
  input  logic                  ex_rd_ena,
  output logic                  mem_allowin,
  output logic                  mem_to_wb_valid,
  output pipe_pkg::pc_t         wb_pc,
  output pipe_pkg::inst_t       wb_inst,
  output logic [`XLEN-1:0]      wb_data,
  output pipe_pkg::reg_addr_t   wb_rd_addr,
  output logic                  wb_rd_ena,
  input  logic                  wb_allowin,
  output pipe_pkg::reg_addr_t   fwd_rd_addr,
  output logic                  fwd_rd_ena,
  output logic [`XLEN-1:0]      fwd_data,
  output logic                  fwd_data_ok,
  output logic                  mem_rw_valid,
  input  logic                  mem_rw_ready,
  output logic                  mem_rw_req,
  output logic [`XLEN-1:0]      mem_rw_addr,
  output lsu_pkg::access_size_e mem_rw_size,
  output logic [7:0]            mem_rw_strb,
  output logic [`XLEN-1:0]      mem_w_data,
  input  logic [`XLEN-1:0]      mem_r_data
);

  logic              capture;
  logic              rsp_take;
  logic              mem_busy;
  logic              held;
  lsu_pkg::ex_word_u mem_word;
  lsu_pkg::mem_op_e  mem_op;

  mem_ctrl ctrl_i (
    .clk             (clk),
    .rst             (rst),
    .ex_valid        (ex_valid),
    .ex_mem_op       (ex_mem_op),
    .wb_allowin      (wb_allowin),
    .mem_rw_ready    (mem_rw_ready),
    .mem_allowin     (mem_allowin),
    .capture         (capture),
    .mem_to_wb_valid (mem_to_wb_valid),
    .mem_rw_valid    (mem_rw_valid),
    .rsp_take        (rsp_take),
    .mem_busy        (mem_busy)
  );

  mem_req_gen req_i (
    .clk           (clk),
    .capture       (capture),
    .ex_pc         (ex_pc),
    .ex_inst       (ex_inst),
    .ex_word       (ex_word),
    .ex_store_data (ex_store_data),
    .ex_mem_op     (ex_mem_op),
    .ex_rd_addr    (ex_rd_addr),
    .ex_rd_ena     (ex_rd_ena),
    .mem_pc        (wb_pc),
    .mem_inst      (wb_inst),
    .mem_word      (mem_word),
    .mem_op        (mem_op),
    .mem_rd_addr   (wb_rd_addr),
    .mem_rd_ena    (wb_rd_ena),
    .mem_rw_addr   (mem_rw_addr),
    .mem_rw_req    (mem_rw_req),
    .mem_rw_size   (mem_rw_size),
    .mem_rw_strb   (mem_rw_strb),
    .mem_w_data    (mem_w_data)
  );

  mem_load_unit load_i (
    .clk        (clk),
    .rsp_take   (rsp_take),
    .mem_op     (mem_op),
    .mem_word   (mem_word),
    .mem_r_data (mem_r_data),
    .wb_data    (wb_data)
  );

  // an item is held while waiting on memory or on write-back
  assign held = mem_to_wb_valid || mem_rw_valid;

  assign fwd_rd_addr = held ? wb_rd_addr : '0;
  assign fwd_rd_ena  = held && wb_rd_ena;
  assign fwd_data    = held ? wb_data : '0;
  assign fwd_data_ok = !mem_busy;

endmodule

//--- mem_stage_asserts.sv
`timescale 1ns/100ps
`include "mem_stage_defines.svh"

module mem_stage_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  mem_rw_valid,
  input logic                  mem_rw_ready,
  input logic                  mem_rw_req,
  input logic [`XLEN-1:0]      mem_rw_addr,
  input lsu_pkg::access_size_e mem_rw_size,
  input logic [7:0]            mem_rw_strb,
  input logic [`XLEN-1:0]      mem_w_data,
  input logic                  mem_to_wb_valid,
  input logic                  wb_allowin,
  input pipe_pkg::pc_t         wb_pc
);

  int unsigned fail_count = 0;

  // request fields hold until the memory takes them
  req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_rw_valid && !mem_rw_ready |=> mem_rw_valid && $stable(mem_rw_addr)
      && $stable(mem_rw_size) && $stable(mem_rw_strb) && $stable(mem_w_data)
      && $stable(mem_rw_req))
    else begin
      fail_count++;
      $error("memory request changed or dropped before mem_rw_ready");
    end

  no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(mem_to_wb_valid && mem_rw_valid))
    else begin
      fail_count++;
      $error("mem_to_wb_valid and mem_rw_valid high together");
    end

  // finished item waits for write-back
  wb_hold: assert property (@(posedge clk) disable iff (rst)
    mem_to_wb_valid && !wb_allowin |=> mem_to_wb_valid && $stable(wb_pc))
    else begin
      fail_count++;
      $error("item left or changed while write-back held it off");
    end

  reset_idle: assert property (@(posedge clk)
    rst |=> !mem_rw_valid && !mem_to_wb_valid)
    else begin
      fail_count++;
      $error("valid outputs active after reset");
    end

endmodule

//--- mem_stage_defines.svh
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// data and address width
`define XLEN 64

`define INST_W 32

// integer register index
`define REG_ADDR_W 5

`endif

//--- pipe_pkg.sv
`include "mem_stage_defines.svh"

package pipe_pkg;

  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`XLEN-1:0] pc_t;

  // raw instruction word
  typedef logic [`INST_W-1:0] inst_t;

endpackage

//--- tb_mem_stage.sv
`timescale 1ns/100ps
`include "mem_stage_defines.svh"

module tb_mem_stage;

  localparam int N_ITEMS = 400;

  typedef struct {
    pipe_pkg::pc_t         pc;
    pipe_pkg::inst_t       inst;
    pipe_pkg::reg_addr_t   rd;
    logic                  ena;
    lsu_pkg::mem_op_e      op;
    logic [`XLEN-1:0]      word;
    logic [`XLEN-1:0]      data;
    lsu_pkg::access_size_e size;
    logic [7:0]            strb;
    logic [`XLEN-1:0]      wdata;
  } item_t;

  logic                  clk, rst, ex_valid, ex_rd_ena, wb_allowin, mem_rw_ready;
  pipe_pkg::pc_t         ex_pc, wb_pc;
  pipe_pkg::inst_t       ex_inst, wb_inst;
  lsu_pkg::ex_word_u     ex_word;
  lsu_pkg::mem_op_e      ex_mem_op;
  pipe_pkg::reg_addr_t   ex_rd_addr, wb_rd_addr, fwd_rd_addr;
  logic [`XLEN-1:0]      ex_store_data, wb_data, fwd_data, mem_r_data;
  logic [`XLEN-1:0]      mem_rw_addr, mem_w_data;
  logic                  mem_allowin, mem_to_wb_valid, wb_rd_ena, fwd_rd_ena, fwd_data_ok;
  logic                  mem_rw_valid, mem_rw_req;
  lsu_pkg::access_size_e mem_rw_size;
  logic [7:0]            mem_rw_strb;

  logic [`XLEN-1:0] resp_mem [256];
  logic [`XLEN-1:0] model_mem [256];
  item_t            model_q [$];
  item_t            next_item;
  integer           seed = 48210;
  int               sent;
  int               retired;
  int               delay;
  logic             head_back;
  logic             head_done;

  mem_stage dut_i (.*);

  bind mem_stage mem_stage_asserts asserts_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pc(string name, pipe_pkg::pc_t exp, pipe_pkg::pc_t act);
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_inst(string name, pipe_pkg::inst_t exp, pipe_pkg::inst_t act);
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_reg(string name, pipe_pkg::reg_addr_t exp, pipe_pkg::reg_addr_t act);
    if (exp !== act) begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mem_req(string name, lsu_pkg::access_size_e exp_size,
                               logic [7:0] exp_strb, lsu_pkg::access_size_e act_size,
                               logic [7:0] act_strb);
    if (exp_size !== act_size || exp_strb !== act_strb) begin
      $display("error %s: expected size %0d strobe %h, actual size %0d strobe %h",
               name, exp_size, exp_strb, act_size, act_strb);
      abort_run();
    end
  endtask

  // new random item and its expected results from the model memory
  task automatic drive_item();
    item_t               it;
    lsu_pkg::ex_word_u   w;
    logic [`XLEN-1:0]    sd;
    logic [`XLEN-1:0]    mask;
    logic [`XLEN-1:0]    raw;
    logic [7:0]          idx;
    lsu_pkg::byte_off_t  off;
    int                  nb;
    it.op    = lsu_pkg::mem_op_e'($unsigned($random(seed)) % 12);
    it.pc    = {$random(seed), $random(seed)};
    it.inst  = $random(seed);
    it.rd    = pipe_pkg::reg_addr_t'($random(seed));
    it.ena   = 1'($random(seed));
    sd       = {$random(seed), $random(seed)};
    w.result = {$random(seed), $random(seed)};
    case (it.op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: it.size = lsu_pkg::SIZE_B;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: it.size = lsu_pkg::SIZE_H;
      lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: it.size = lsu_pkg::SIZE_W;
      default:                                it.size = lsu_pkg::SIZE_D;
    endcase
    nb   = 1 << it.size;
    mask = (nb == 8) ? '1 : (64'd1 << (8 * nb)) - 64'd1;
    idx  = 8'($random(seed));
    off  = lsu_pkg::byte_off_t'(($unsigned($random(seed)) % 8) / nb * nb);
    if (lsu_pkg::is_load(it.op) || lsu_pkg::is_store(it.op)) begin
      w.addr.dw_idx = {{(`XLEN-11){1'b0}}, idx};
      w.addr.off    = off;
    end
    it.word  = w.result;
    it.data  = w.result;
    it.strb  = 8'((9'd1 << nb) - 9'd1) << off;
    it.wdata = sd & mask;
    if (lsu_pkg::is_store(it.op)) begin
      for (int k = 0; k < nb; k++) begin
        model_mem[idx][8*(off+k) +: 8] = sd[8*k +: 8];
      end
    end
    if (lsu_pkg::is_load(it.op)) begin
      raw     = model_mem[idx] >> (8 * off);
      it.data = raw & mask;
      if (it.op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW} && raw[8*nb-1]) begin
        it.data = it.data | ~mask;
      end
    end
    ex_valid      <= 1'b1;
    ex_pc         <= it.pc;
    ex_inst       <= it.inst;
    ex_word       <= w;
    ex_store_data <= sd;
    ex_mem_op     <= it.op;
    ex_rd_addr    <= it.rd;
    ex_rd_ena     <= it.ena;
    next_item     <= it;
  endtask

  // checks first on pre-edge values, then the memory responder, then new stimulus
  always @(posedge clk) begin
    if (!rst) begin
      if (dut_i.asserts_i.fail_count != 0) begin
        $display("a concurrent assertion on the DUT failed");
        abort_run();
      end
      // head is finished once it needs no access or its access is done
      head_done = model_q.size() != 0 && (!(lsu_pkg::is_load(model_q[0].op)
                  || lsu_pkg::is_store(model_q[0].op)) || head_back);
      check_flag("mem_to_wb_valid", head_done, mem_to_wb_valid);
      check_flag("mem_rw_valid", model_q.size() != 0 && !head_done, mem_rw_valid);
      check_flag("mem_allowin", model_q.size() == 0 || (head_done && wb_allowin),
                 mem_allowin);
      check_flag("fwd_data_ok", model_q.size() == 0 || !lsu_pkg::is_load(model_q[0].op)
                 || head_back, fwd_data_ok);
      if (model_q.size() != 0) begin
        check_reg("fwd_rd_addr", model_q[0].rd, fwd_rd_addr);
        check_flag("fwd_rd_ena", model_q[0].ena, fwd_rd_ena);
        if (fwd_data_ok) begin
          check_word("fwd_data", model_q[0].data, fwd_data);
        end
      end
      if (mem_rw_valid && mem_rw_ready) begin
        check_mem_req("mem_req", model_q[0].size, model_q[0].strb, mem_rw_size, mem_rw_strb);
        check_word("mem_rw_addr", model_q[0].word, mem_rw_addr);
        check_flag("mem_rw_req", lsu_pkg::is_store(model_q[0].op), mem_rw_req);
        if (mem_rw_req) begin
          check_word("mem_w_data", model_q[0].wdata, mem_w_data);
          for (int i = 0; i < 8; i++) begin
            if (mem_rw_strb[i]) begin
              resp_mem[mem_rw_addr[10:3]][8*i +: 8] =
                mem_w_data[8*(i - int'(mem_rw_addr[2:0])) +: 8];
            end
          end
        end
        head_back = 1'b1;
        mem_rw_ready <= 1'b0;
        delay = $unsigned($random(seed)) % 4;
      end else if (mem_rw_valid) begin
        if (delay == 0) begin
          mem_rw_ready <= 1'b1;
          mem_r_data   <= resp_mem[mem_rw_addr[10:3]] >> (8 * mem_rw_addr[2:0]);
        end else begin
          delay--;
        end
      end
      if (mem_to_wb_valid && wb_allowin) begin
        check_pc("wb_pc", model_q[0].pc, wb_pc);
        check_inst("wb_inst", model_q[0].inst, wb_inst);
        check_reg("wb_rd_addr", model_q[0].rd, wb_rd_addr);
        check_flag("wb_rd_ena", model_q[0].ena, wb_rd_ena);
        check_word("wb_data", model_q[0].data, wb_data);
        void'(model_q.pop_front());
        head_back = 1'b0;
        retired++;
      end
      if (ex_valid && mem_allowin) begin
        model_q.push_back(next_item);
      end
      if (!ex_valid || mem_allowin) begin
        if (sent < N_ITEMS && ($unsigned($random(seed)) % 4) != 0) begin
          drive_item();
          sent++;
        end else begin
          ex_valid <= 1'b0;
        end
      end
      wb_allowin <= ($unsigned($random(seed)) % 4) != 0;
    end
  end

  initial begin
    rst           = 1'b1;
    ex_valid      = 1'b0;
    ex_pc         = '0;
    ex_inst       = '0;
    ex_word       = '0;
    ex_store_data = '0;
    ex_mem_op     = lsu_pkg::NONE;
    ex_rd_addr    = '0;
    ex_rd_ena     = 1'b0;
    wb_allowin    = 1'b0;
    mem_rw_ready  = 1'b0;
    mem_r_data    = '0;
    sent          = 0;
    retired       = 0;
    delay         = 0;
    head_back     = 1'b0;
    for (int i = 0; i < 256; i++) begin
      resp_mem[i]  = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);
      model_mem[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);
    end
    repeat (8) @(posedge clk);
    check_flag("reset mem_to_wb_valid", 1'b0, mem_to_wb_valid);
    check_flag("reset mem_rw_valid", 1'b0, mem_rw_valid);
    check_flag("reset mem_allowin", 1'b1, mem_allowin);
    rst <= 1'b0;
    for (int t = 0; t < 50000 && retired < N_ITEMS; t++) begin
      @(posedge clk);
    end
    if (retired != N_ITEMS) begin
      $display("timeout: %0d of %0d items reached write-back", retired, N_ITEMS);
      abort_run();
    end else if (dut_i.asserts_i.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("a concurrent assertion on the DUT failed");
      abort_run();
    end
  end

endmodule
